// File: vlog.f
+incdir+bench
src/cpu_pkg.sv
src/cpu_stage_if.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_result.sv
src/cpu.sv
bench/cpu_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpu_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/cpu_tb_prog.svh
`ifndef CPU_TB_PROG_SVH
`define CPU_TB_PROG_SVH

//////////////////////////////////////////////////////////////////////
// Instruction encoding
//////////////////////////////////////////////////////////////////////

function automatic logic [15:0] enc_r(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
                                      logic [3:0] rt);
    return {op, rd, rs, rt};
endfunction

function automatic logic [15:0] enc_i(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
endfunction

function automatic logic [15:0] enc_b(logic [2:0] cond, logic [8:0] off);
    return {op_b, cond, off};
endfunction

// Append one word, tagged with the current test
task automatic emit(logic [15:0] word);
    rom[prog_len] = word;
    rom_test[prog_len] = cur_test;
    prog_len++;
endtask

// Full word by low then high byte
task automatic load_const(logic [3:0] rd, logic [15:0] val);
    emit(enc_i(op_llb, rd, val[7:0]));
    emit(enc_i(op_lhb, rd, val[15:8]));
endtask

//////////////////////////////////////////////////////////////////////
// Test program
//////////////////////////////////////////////////////////////////////

task automatic build_program();
    logic [31:0] rnd;
    logic [15:0] v [4];
    // Unused words decode as HLT, low bits carry the address
    for (int i = 0; i < rom_words; i++) begin
        rom[i] = {op_hlt, 12'(i)};
        rom_test[i] = 5;
    end
    for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        v[i] = rnd[15:0];
    end

    // ALU chain, saturation and shifts
    cur_test = 0;
    load_const(1, v[0]);
    load_const(2, v[1]);
    load_const(3, 16'h7000);
    load_const(4, 16'h9000);
    emit(enc_r(op_add, 5, 1, 2));
    // r5 from execute forwarding
    emit(enc_r(op_sub, 6, 5, 1));
    // r5 through the register file bypass, r6 forwarded
    emit(enc_r(op_xor, 7, 5, 6));
    emit(enc_r(op_add, 8, 3, 3));
    emit(enc_r(op_add, 9, 4, 4));
    emit(enc_r(op_sub, 10, 3, 4));
    emit(enc_r(op_sub, 11, 4, 3));
    emit(enc_r(op_sll, 12, 1, v[2][3:0]));
    emit(enc_r(op_sra, 13, 4, v[3][3:0]));
    emit(enc_r(op_ror, 14, 12, v[2][7:4]));
    emit(enc_r(op_sra, 13, 13, 15));

    // Byte loads back to back on one register
    cur_test = 1;
    rnd = $random(seed);
    emit(enc_i(op_llb, 1, rnd[7:0]));
    emit(enc_i(op_lhb, 1, rnd[15:8]));
    emit(enc_i(op_lhb, 2, rnd[23:16]));
    emit(enc_i(op_llb, 2, rnd[31:24]));
    emit(enc_r(op_add, 3, 1, 2));

    // Store then load, odd base gets bit 0 cleared
    cur_test = 2;
    rnd = $random(seed);
    load_const(1, {rnd[15:1], 1'b1});
    load_const(2, rnd[31:16]);
    emit(enc_r(op_sw, 2, 1, 0));
    emit(enc_r(op_lw, 3, 1, 0));
    // Store data straight from the load before it
    emit(enc_r(op_sw, 3, 1, 1));
    emit(enc_r(op_lw, 4, 1, 1));
    emit(enc_r(op_lw, 5, 1, 0));
    emit(enc_r(op_sw, 2, 1, 4'hf));
    emit(enc_r(op_lw, 6, 1, 4'hf));
    emit(enc_r(op_add, 7, 2, 1));
    // Address and data both from the ADD just before
    emit(enc_r(op_sw, 7, 7, 2));
    emit(enc_r(op_lw, 8, 7, 2));
    emit(enc_r(op_add, 9, 8, 4));

    // Register 0
    cur_test = 3;
    emit(enc_r(op_add, 0, 1, 2));
    emit(enc_i(op_llb, 0, 8'h5a));
    emit(enc_r(op_add, 5, 0, 1));
    emit(enc_r(op_xor, 6, 0, 0));
    emit(enc_r(op_sub, 7, 2, 0));

    // Every condition against five flag setups, poison word behind each B
    cur_test = 4;
    load_const(1, 16'h0001);
    load_const(2, 16'h0002);
    load_const(3, 16'h7fff);
    for (int c = 0; c < 8; c++) begin
        emit(enc_r(op_sub, 9, 1, 1));
        emit(enc_b(3'(c), 9'd1));
        emit(enc_i(op_llb, 15, 8'(c * 16)));
        emit(enc_r(op_sub, 9, 1, 2));
        emit(enc_b(3'(c), 9'd1));
        emit(enc_i(op_llb, 15, 8'(c * 16 + 1)));
        emit(enc_r(op_sub, 9, 2, 1));
        emit(enc_b(3'(c), 9'd1));
        emit(enc_i(op_llb, 15, 8'(c * 16 + 2)));
        emit(enc_r(op_add, 9, 3, 1));
        emit(enc_b(3'(c), 9'd1));
        emit(enc_i(op_llb, 15, 8'(c * 16 + 3)));
        // XOR changes z only, v stays from the ADD
        emit(enc_r(op_xor, 9, 1, 2));
        emit(enc_b(3'(c), 9'd1));
        emit(enc_i(op_llb, 15, 8'(c * 16 + 4)));
    end

    // Halt with live words behind it
    cur_test = 5;
    rnd = $random(seed);
    emit(enc_i(op_llb, 11, rnd[7:0]));
    emit(enc_r(op_add, 12, 11, 11));
    emit(enc_r(op_hlt, 0, 0, 0));
    emit(enc_i(op_llb, 13, 8'h77));
    emit(enc_r(op_add, 14, 11, 11));
endtask

//////////////////////////////////////////////////////////////////////
// Sequential ISA model
//////////////////////////////////////////////////////////////////////

task automatic run_model();
    logic [15:0] regs [16];
    logic [15:0] mem [256];
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  sh;
    logic        z;
    logic        v;
    logic        n;
    logic        wr;
    logic        take;
    int          pc;
    int          sum;
    int          steps;
    foreach (regs[i]) regs[i] = '0;
    {z, v, n} = 3'b000;
    pc = 0;
    steps = 0;
    exp_n = 0;
    while (steps < rom_words) begin
        w = rom[pc];
        op = w[15:12];
        rd = w[11:8];
        sh = w[3:0];
        a = regs[w[7:4]];
        b = regs[w[3:0]];
        res = '0;
        wr = 1'b1;
        // Memory address, word aligned base plus signed word offset
        addr = {a[15:1], 1'b0} + {{11{sh[3]}}, sh, 1'b0};
        steps++;
        if (op == op_hlt) begin
            break;
        end
        case (op)
            op_add, op_sub: begin
                if (op == op_add) begin
                    sum = int'($signed(a)) + int'($signed(b));
                end else begin
                    sum = int'($signed(a)) - int'($signed(b));
                end
                v = (sum > 32767) || (sum < -32768);
                if (sum > 32767) res = 16'h7fff;
                else if (sum < -32768) res = 16'h8000;
                else res = sum[15:0];
                z = (res == 16'h0000);
                n = res[15];
            end
            op_xor: res = a ^ b;
            op_sll: res = a << sh;
            op_sra: res = $signed(a) >>> sh;
            op_ror: res = (a >> sh) | (a << (5'd16 - {1'b0, sh}));
            op_lw:  res = mem[addr[8:1]];
            op_llb: res = {regs[rd][15:8], w[7:0]};
            op_lhb: res = {w[7:0], regs[rd][7:0]};
            default: wr = 1'b0;
        endcase
        if (op inside {op_xor, op_sll, op_sra, op_ror}) begin
            z = (res == 16'h0000);
        end
        if (op == op_sw) begin
            mem[addr[8:1]] = regs[rd];
        end
        take = 1'b0;
        if (op == op_b) begin
            case (w[11:9])
                cond_ne: take = !z;
                cond_eq: take = z;
                cond_gt: take = !z && !n;
                cond_lt: take = n;
                cond_ge: take = !n;
                cond_le: take = z || n;
                cond_ov: take = v;
                default: take = 1'b1;
            endcase
        end
        if (wr && rd != 4'd0) begin
            regs[rd] = res;
            exp_reg[exp_n] = rd;
            exp_data[exp_n] = res;
            exp_test[exp_n] = rom_test[pc];
            test_last[rom_test[pc]] = exp_n;
            exp_n++;
        end
        pc = take ? pc + 1 + int'($signed(w[8:0])) : pc + 1;
    end
endtask

`endif

// File: bench/cpu_tb.sv
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int rom_words = 512;
    localparam int exp_max = 1024;

    logic        clk;
    logic        rst_n;
    logic [15:0] imem_addr;
    logic [15:0] imem_data;
    logic        hlt;
    logic        wb_en;
    logic [3:0]  wb_reg;
    logic [15:0] wb_data;

    // Program image and owning test per word
    logic [15:0] rom [rom_words];
    int          rom_test [rom_words];
    int          prog_len;
    int          cur_test;
    integer      seed;

    // Expected writebacks in program order
    logic [3:0]  exp_reg [exp_max];
    logic [15:0] exp_data [exp_max];
    int          exp_test [exp_max];
    int          exp_n;

    string       test_name [6];
    int          test_last [6];
    int          test_errs [6];
    int          cur_idx;
    int          wb_count;
    int          pend_idx;
    logic        pend;
    int          errors;
    int          cycles;
    int          limit;

    `include "cpu_tb_prog.svh"

    cpu uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .hlt       (hlt),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n) cycles++;
    end

    ////////////////////////////////////////////////////////////////////
    // ROM and writeback bookkeeping on the falling edge
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        imem_data <= rom[imem_addr[9:1]];
        // Previous writeback has been checked at the rising edge
        if (pend && pend_idx < exp_n && test_last[exp_test[pend_idx]] == pend_idx) begin
            $display("test %s: %0d errors", test_name[exp_test[pend_idx]],
                     test_errs[exp_test[pend_idx]]);
        end
        pend = wb_en;
        pend_idx = wb_count;
        cur_idx = wb_count;
        if (wb_en) wb_count++;
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    a_wb_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (cur_idx < exp_n && wb_reg == exp_reg[cur_idx]
                   && wb_data == exp_data[cur_idx]))
    else begin
        errors++;
        if (cur_idx >= exp_n) begin
            $display("writeback to r%0d came after the last expected one",
                     $sampled(wb_reg));
        end else begin
            test_errs[exp_test[cur_idx]]++;
            $display("Fail %s entry %0d: expected r%0d=%h, actual r%0d=%h",
                     test_name[exp_test[cur_idx]], cur_idx, exp_reg[cur_idx],
                     exp_data[cur_idx], $sampled(wb_reg), $sampled(wb_data));
        end
    end

    a_no_r0: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_reg != 4'd0)
    else begin
        errors++;
        $display("a write to register 0 reached the writeback port");
    end

    // Halted core keeps its PC and writes nothing more
    a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hlt |=> hlt && $stable(imem_addr) && !wb_en)
    else begin
        errors++;
        $display("after halt the PC moved, hlt dropped or a writeback appeared");
    end

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        imem_data = '0;
        seed = 32'h8b80;
        prog_len = 0;
        cur_test = 0;
        errors = 0;
        cycles = 0;
        wb_count = 0;
        cur_idx = 0;
        pend = 1'b0;
        pend_idx = 0;
        test_name = '{"alu", "bytes", "memory", "r0", "branch", "halt"};
        foreach (test_last[i]) test_last[i] = -1;
        foreach (test_errs[i]) test_errs[i] = 0;
        build_program();
        run_model();
        // Straight-line code, at most one lost slot per word
        limit = 2 * prog_len + 50;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        while (!hlt && cycles < limit) @(negedge clk);
        if (!hlt) begin
            errors++;
            $display("timeout: hlt did not rise within %0d cycles", limit);
        end else begin
            repeat (4) @(negedge clk);
        end
        if (wb_count != exp_n) begin
            errors++;
            $display("saw %0d writebacks where %0d were expected", wb_count, exp_n);
        end
        $display("words %0d, writebacks %0d of %0d, errors %0d",
                 prog_len, wb_count, exp_n, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/cpu.sv
`default_nettype none

module cpu (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [cpu_pkg::data_w-1:0] imem_addr,
    input  logic [cpu_pkg::data_w-1:0] imem_data,
    output logic                       hlt,
    output logic                       wb_en,
    output logic [cpu_pkg::reg_w-1:0]  wb_reg,
    output logic [cpu_pkg::data_w-1:0] wb_data
);
    import cpu_pkg::*;

    logic              redirect;
    logic [data_w-1:0] target;

    // Stage links
    dec_exe_if dx ();
    exe_res_if xr ();
    wb_if      wb ();

    cpu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .redirect  (redirect),
        .target    (target),
        .dx        (dx),
        .wb        (wb)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .dx       (dx),
        .xr       (xr),
        .wb       (wb),
        .redirect (redirect),
        .target   (target)
    );

    cpu_result u_result (
        .clk   (clk),
        .rst_n (rst_n),
        .xr    (xr),
        .wb    (wb),
        .hlt   (hlt)
    );

    // Writeback visible at the top
    assign wb_en   = wb.wr_en;
    assign wb_reg  = wb.wr_reg;
    assign wb_data = wb.wr_data;

endmodule

`default_nettype wire

// File: src/cpu_result.sv
`default_nettype none

module cpu_result (
    input  logic      clk,
    input  logic      rst_n,
    exe_res_if.sink   xr,
    wb_if.source      wb,
    output logic      hlt
);
    import cpu_pkg::*;

    logic [data_w-1:0]  dmem [dmem_depth];
    logic [dmem_aw-1:0] dm_idx;
    logic               hlt_q;
    logic               hlt_now;

    //////////////////////////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////////////////////////

    // Word index from the byte address
    assign dm_idx = xr.alu_out[dmem_aw:1];

    always_ff @(posedge clk) begin
        if (xr.valid && xr.opcode == op_sw) begin
            dmem[dm_idx] <= xr.store_data;
        end
    end

    // Load data is ready in the same cycle
    assign wb.wr_en   = xr.wr_en;
    assign wb.wr_reg  = xr.rd;
    assign wb.wr_data = (xr.opcode == op_lw) ? dmem[dm_idx] : xr.alu_out;

    //////////////////////////////////////////////////////////////////////
    // Halt
    //////////////////////////////////////////////////////////////////////

    assign hlt_now = xr.valid && (xr.opcode == op_hlt);

    // Sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hlt_q <= 1'b0;
        end else if (hlt_now) begin
            hlt_q <= 1'b1;
        end
    end

    assign hlt = hlt_q || hlt_now;

    // Decode drops writes to r0 before they get here
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb.wr_en |-> wb.wr_reg != '0)
        else $error("writeback to r0");

endmodule

`default_nettype wire

// File: src/cpu_execute.sv
`default_nettype none

module cpu_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    dec_exe_if.sink                    dx,
    exe_res_if.source                  xr,
    wb_if.sink                         wb,
    output logic                       redirect,
    output logic [cpu_pkg::data_w-1:0] target
);
    import cpu_pkg::*;

    logic              ex_valid;
    logic              ex_wr_en;
    instr_u            ex_instr;
    logic [data_w-1:0] ex_pc_next;
    logic [reg_w-1:0]  ex_rs_idx;
    logic [reg_w-1:0]  ex_rt_idx;
    logic [data_w-1:0] ex_rs_data;
    logic [data_w-1:0] ex_rt_data;
    logic [op_w-1:0]   ex_op;
    logic [data_w-1:0] src_a;
    logic [data_w-1:0] src_b;
    logic [data_w-1:0] add_raw;
    logic [data_w-1:0] sub_raw;
    logic              add_ovf;
    logic              sub_ovf;
    logic [2*data_w-1:0] rot;
    logic [data_w-1:0] mem_off;
    logic [data_w-1:0] br_off;
    logic [data_w-1:0] alu_out;
    flags_t            flags;
    flags_t            flags_nxt;
    logic              cond_ok;

    //////////////////////////////////////////////////////////////////////
    // Slot register and forwarding
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wr_en <= 1'b0;
        end else begin
            ex_valid <= dx.valid;
            ex_wr_en <= dx.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_instr   <= dx.instr;
        ex_pc_next <= dx.pc_next;
        ex_rs_idx  <= dx.rs_idx;
        ex_rt_idx  <= dx.rt_idx;
        ex_rs_data <= dx.rs_data;
        ex_rt_data <= dx.rt_data;
    end

    assign ex_op = ex_instr.r.opcode;

    // Result stage holds the previous instruction
    assign src_a = (wb.wr_en && wb.wr_reg == ex_rs_idx && ex_rs_idx != '0) ?
                   wb.wr_data : ex_rs_data;
    assign src_b = (wb.wr_en && wb.wr_reg == ex_rt_idx && ex_rt_idx != '0) ?
                   wb.wr_data : ex_rt_data;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    assign add_raw = src_a + src_b;
    assign sub_raw = src_a - src_b;
    // Signed overflow on operand and result signs
    assign add_ovf = (src_a[data_w-1] == src_b[data_w-1])
                  && (add_raw[data_w-1] != src_a[data_w-1]);
    assign sub_ovf = (src_a[data_w-1] != src_b[data_w-1])
                  && (sub_raw[data_w-1] != src_a[data_w-1]);
    assign rot     = {src_a, src_a} >> ex_instr.r.rt;
    // Word offset sign-extended from 4 bits
    assign mem_off = {{(data_w-5){ex_instr.r.rt[3]}}, ex_instr.r.rt, 1'b0};

    always_comb begin
        alu_out   = src_a;
        flags_nxt = flags;
        case (ex_op)
            op_add: begin
                alu_out     = add_ovf ? (src_a[data_w-1] ? sat_min : sat_max) : add_raw;
                flags_nxt.z = (alu_out == '0);
                flags_nxt.v = add_ovf;
                flags_nxt.n = alu_out[data_w-1];
            end
            op_sub: begin
                alu_out     = sub_ovf ? (src_a[data_w-1] ? sat_min : sat_max) : sub_raw;
                flags_nxt.z = (alu_out == '0);
                flags_nxt.v = sub_ovf;
                flags_nxt.n = alu_out[data_w-1];
            end
            // Logic and shifts touch z only
            op_xor: begin
                alu_out     = src_a ^ src_b;
                flags_nxt.z = (alu_out == '0);
            end
            op_sll: begin
                alu_out     = src_a << ex_instr.r.rt;
                flags_nxt.z = (alu_out == '0);
            end
            op_sra: begin
                alu_out     = $signed(src_a) >>> ex_instr.r.rt;
                flags_nxt.z = (alu_out == '0);
            end
            op_ror: begin
                alu_out     = rot[data_w-1:0];
                flags_nxt.z = (alu_out == '0);
            end
            // Base is forced even
            op_lw, op_sw: begin
                alu_out = {src_a[data_w-1:1], 1'b0} + mem_off;
            end
            op_llb: begin
                alu_out = {src_a[data_w-1:imm_w], ex_instr.i.imm};
            end
            op_lhb: begin
                alu_out = {ex_instr.i.imm, src_a[imm_w-1:0]};
            end
            default: begin
                alu_out = src_a;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ex_valid) begin
            flags <= flags_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Branch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cond_ok = 1'b1;
        case (ex_instr.b.cond)
            cond_ne: cond_ok = !flags.z;
            cond_eq: cond_ok = flags.z;
            cond_gt: cond_ok = !flags.z && !flags.n;
            cond_lt: cond_ok = flags.n;
            cond_ge: cond_ok = !flags.n;
            cond_le: cond_ok = flags.z || flags.n;
            cond_ov: cond_ok = flags.v;
            cond_un: cond_ok = 1'b1;
            default: cond_ok = 1'b1;
        endcase
    end

    assign br_off   = {{(data_w-off_w-1){ex_instr.b.off[off_w-1]}}, ex_instr.b.off, 1'b0};
    assign target   = ex_pc_next + br_off;
    assign redirect = ex_valid && (ex_op == op_b) && cond_ok;

    //////////////////////////////////////////////////////////////////////
    // Result stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr.valid <= 1'b0;
            xr.wr_en <= 1'b0;
        end else begin
            xr.valid <= ex_valid;
            xr.wr_en <= ex_valid && ex_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        xr.opcode     <= ex_op;
        xr.rd         <= ex_instr.r.rd;
        xr.alu_out    <= alu_out;
        xr.store_data <= src_b;
    end

    // Opcodes 3, 7, D and E pass as no-ops
    a_no_bad_op: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |-> !(ex_op inside {4'h3, 4'h7, 4'hd, 4'he}))
        else $error("unsupported opcode %h in execute", ex_op);

    // Taken branch squashes the slot behind it
    a_redirect_b: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> (ex_valid && ex_op == op_b) ##1 !ex_valid)
        else $error("redirect without a valid B or without a flush");

endmodule

`default_nettype wire

// File: src/cpu_decode.sv
`default_nettype none

module cpu_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [cpu_pkg::data_w-1:0] imem_addr,
    input  cpu_pkg::instr_u            imem_data,
    input  logic                       redirect,
    input  logic [cpu_pkg::data_w-1:0] target,
    dec_exe_if.source                  dx,
    wb_if.sink                         wb
);
    import cpu_pkg::*;

    logic [data_w-1:0] pc;
    logic [data_w-1:0] pc_next;
    // Set once HLT has left decode
    logic              halted;
    logic              is_hlt;
    logic              slot_ok;
    logic [data_w-1:0] regs [reg_cnt];
    logic              wr_ok;
    logic [reg_w-1:0]  rs_idx;
    logic [reg_w-1:0]  rt_idx;
    logic              writes_reg;

    //////////////////////////////////////////////////////////////////////
    // PC
    //////////////////////////////////////////////////////////////////////

    assign imem_addr = pc;
    assign pc_next   = pc + pc_step;
    assign is_hlt    = (imem_data.r.opcode == op_hlt);
    // Slot dies under a taken branch or after halt
    assign slot_ok   = !halted && !redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            // Redirect wins over a HLT sitting in decode
            if (redirect) begin
                pc <= target;
            end else if (!halted && !is_hlt) begin
                pc <= pc_next;
            end
            if (slot_ok && is_hlt) begin
                halted <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    // r0 is never written, so it reads zero
    assign wr_ok = wb.wr_en && (wb.wr_reg != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb.wr_reg] <= wb.wr_data;
        end
    end

    // Same-cycle write passes straight to the read
    assign dx.rs_data = (wr_ok && wb.wr_reg == rs_idx) ? wb.wr_data : regs[rs_idx];
    assign dx.rt_data = (wr_ok && wb.wr_reg == rt_idx) ? wb.wr_data : regs[rt_idx];

    //////////////////////////////////////////////////////////////////////
    // Field decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rs_idx     = '0;
        rt_idx     = '0;
        writes_reg = 1'b0;
        case (imem_data.r.opcode)
            op_add, op_sub, op_xor: begin
                rs_idx     = imem_data.r.rs;
                rt_idx     = imem_data.r.rt;
                writes_reg = 1'b1;
            end
            // Shift amount and load offset sit in the rt field
            op_sll, op_sra, op_ror, op_lw: begin
                rs_idx     = imem_data.r.rs;
                writes_reg = 1'b1;
            end
            // Store data comes from rd
            op_sw: begin
                rs_idx = imem_data.r.rs;
                rt_idx = imem_data.r.rd;
            end
            // Byte loads modify rd in place
            op_llb, op_lhb: begin
                rs_idx     = imem_data.r.rd;
                writes_reg = 1'b1;
            end
            // B, HLT and the unused opcodes write nothing
            default: begin
                writes_reg = 1'b0;
            end
        endcase
    end

    assign dx.valid   = slot_ok;
    assign dx.instr   = imem_data;
    assign dx.pc_next = pc_next;
    assign dx.rs_idx  = rs_idx;
    assign dx.rt_idx  = rt_idx;
    assign dx.wr_en   = slot_ok && writes_reg && (imem_data.r.rd != '0);

    // Execute holds only bubbles straight out of reset
    a_no_early_redirect: assert property (@(posedge clk) $rose(rst_n) |-> !redirect)
        else $error("redirect on the first cycle after reset");

endmodule

`default_nettype wire

// File: src/cpu_stage_if.sv
`default_nettype none

// Decode to execute slot
interface dec_exe_if;
    import cpu_pkg::*;

    // Low means bubble
    logic              valid;
    instr_u            instr;
    // Address of the following instruction
    logic [data_w-1:0] pc_next;
    logic [reg_w-1:0]  rs_idx;
    logic [reg_w-1:0]  rt_idx;
    logic [data_w-1:0] rs_data;
    logic [data_w-1:0] rt_data;
    // Set only for a live write to a non-zero register
    logic              wr_en;

    modport source (output valid, instr, pc_next, rs_idx, rt_idx, rs_data, rt_data, wr_en);
    modport sink (input valid, instr, pc_next, rs_idx, rt_idx, rs_data, rt_data, wr_en);
endinterface

// Execute to result slot
interface exe_res_if;
    import cpu_pkg::*;

    logic              valid;
    logic [op_w-1:0]   opcode;
    logic [reg_w-1:0]  rd;
    logic              wr_en;
    // ALU result, or the memory address for LW and SW
    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] store_data;

    modport source (output valid, opcode, rd, wr_en, alu_out, store_data);
    modport sink (input valid, opcode, rd, wr_en, alu_out, store_data);
endinterface

// Register writeback from the result stage
interface wb_if;
    import cpu_pkg::*;

    logic              wr_en;
    logic [reg_w-1:0]  wr_reg;
    logic [data_w-1:0] wr_data;

    modport source (output wr_en, wr_reg, wr_data);
    modport sink (input wr_en, wr_reg, wr_data);
endinterface

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Data and address width
    localparam int data_w = 16;
    // Register index and register count
    localparam int reg_w = 4;
    localparam int reg_cnt = 1 << reg_w;
    // Instruction fields
    localparam int op_w = 4;
    localparam int cond_w = 3;
    localparam int imm_w = 8;
    localparam int off_w = 9;

    // Data memory size and word index width
    localparam int dmem_depth = 256;
    localparam int dmem_aw = $clog2(dmem_depth);

    // Byte step between instructions
    localparam logic [data_w-1:0] pc_step = 16'd2;
    // Saturation limits for ADD and SUB
    localparam logic [data_w-1:0] sat_max = 16'h7fff;
    localparam logic [data_w-1:0] sat_min = 16'h8000;

    //////////////////////////////////////////////////////////////////////
    // Opcodes and branch conditions
    //////////////////////////////////////////////////////////////////////

    localparam logic [op_w-1:0] op_add = 4'h0;
    localparam logic [op_w-1:0] op_sub = 4'h1;
    localparam logic [op_w-1:0] op_xor = 4'h2;
    localparam logic [op_w-1:0] op_sll = 4'h4;
    localparam logic [op_w-1:0] op_sra = 4'h5;
    localparam logic [op_w-1:0] op_ror = 4'h6;
    localparam logic [op_w-1:0] op_lw  = 4'h8;
    localparam logic [op_w-1:0] op_sw  = 4'h9;
    localparam logic [op_w-1:0] op_llb = 4'ha;
    localparam logic [op_w-1:0] op_lhb = 4'hb;
    localparam logic [op_w-1:0] op_b   = 4'hc;
    localparam logic [op_w-1:0] op_hlt = 4'hf;

    localparam logic [cond_w-1:0] cond_ne = 3'd0;
    localparam logic [cond_w-1:0] cond_eq = 3'd1;
    localparam logic [cond_w-1:0] cond_gt = 3'd2;
    localparam logic [cond_w-1:0] cond_lt = 3'd3;
    localparam logic [cond_w-1:0] cond_ge = 3'd4;
    localparam logic [cond_w-1:0] cond_le = 3'd5;
    localparam logic [cond_w-1:0] cond_ov = 3'd6;
    localparam logic [cond_w-1:0] cond_un = 3'd7;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // One instruction word, three decodings
    typedef union packed {
        // Register form, also LW and SW with rt as the 4-bit offset
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] rs;
            logic [reg_w-1:0] rt;
        } r;
        // Byte loads
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rd;
            logic [imm_w-1:0] imm;
        } i;
        // Conditional branch
        struct packed {
            logic [op_w-1:0]   opcode;
            logic [cond_w-1:0] cond;
            logic [off_w-1:0]  off;
        } b;
    } instr_u;

    // Flag register
    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flags_t;

endpackage

`default_nettype wire
